//--- run.sh
#!/usr/bin/env bash
# build and run the pi1 wishbone testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_pi1_wb -o tb_pi1_wb
./obj_dir/tb_pi1_wb > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

//--- src/pi1_pkg.sv
// processor port definitions
// operation codes and word widths

package pi1_pkg;

	// data path width.
	localparam int ARCH_W = 32;

	// byte lanes per word.
	localparam int SEL_W = ARCH_W / 8;

	// byte offset bits below the word address.
	localparam int OFF_W = 2;

	// word address width.
	localparam int ADDR_W = ARCH_W - OFF_W;

	// pi1 operation codes, as driven on pi1_op_i.
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR  = 2'b01,
		PI1_RD  = 2'b10,
		PI1_RW  = 2'b11 // swap, returns old word.
	} pi1_op_e;

endpackage

//--- src/pi1_to_wb4.sv
// pi1 to wishbone b4 bridge
`timescale 1ns/100ps

module pi1_to_wb4 (
	input  logic                            clk_i,
	input  logic                            rst_i,

	input  pi1_pkg::pi1_op_e                pi1_op_i,
	input  logic [pi1_pkg::ADDR_W-1:0]      pi1_addr_i,
	input  logic [pi1_pkg::ARCH_W-1:0]      pi1_data_i,
	input  logic [pi1_pkg::SEL_W-1:0]       pi1_sel_i,
	output logic [pi1_pkg::ARCH_W-1:0]      pi1_data_o,
	output logic                            pi1_rdy_o,

	output logic                            wb4_cyc_o,
	output logic                            wb4_stb_o,
	output logic                            wb4_we_o,
	output logic [wb_pkg::WB_ADDR_W-1:0]    wb4_addr_o,
	output logic [pi1_pkg::ARCH_W-1:0]      wb4_data_o,
	output logic [pi1_pkg::SEL_W-1:0]       wb4_sel_o,
	input  logic                            wb4_stall_i,
	input  logic                            wb4_ack_i,
	input  logic [pi1_pkg::ARCH_W-1:0]      wb4_data_i
);

	logic                            wr_pending;
	pi1_pkg::pi1_op_e                op_hold;
	logic [pi1_pkg::ARCH_W-1:0]      rd_hold;
	logic [pi1_pkg::OFF_W-1:0]       byte_off;
	logic [wb_pkg::WB_ADDR_W-1:0]    byte_addr;
	logic                            done_ack;

	// lowest set select bit gives the byte offset.
	always_comb begin
		byte_off = '0;
		for (int i = pi1_pkg::SEL_W - 1; i >= 0; i--) begin
			if (pi1_sel_i[i])
				byte_off = pi1_pkg::OFF_W'(i);
		end
	end

	assign byte_addr = {pi1_addr_i, byte_off};

	// ack that finishes the operation, not the read half of a swap.
	assign done_ack = !wr_pending && wb4_ack_i;

	assign pi1_rdy_o = !wb4_cyc_o || done_ack;

	assign pi1_data_o = (op_hold == pi1_pkg::PI1_RW) ? rd_hold : wb4_data_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb4_cyc_o  <= 1'b0;
			wb4_stb_o  <= 1'b0;
			wb4_we_o   <= 1'b0;
			wr_pending <= 1'b0;
			op_hold    <= pi1_pkg::PI1_NOP;
		end else if (pi1_rdy_o) begin
			op_hold <= pi1_op_i;
			case (pi1_op_i)
				pi1_pkg::PI1_WR: begin
					wb4_cyc_o <= 1'b1;
					wb4_stb_o <= 1'b1;
					wb4_we_o  <= 1'b1;
				end
				pi1_pkg::PI1_RD: begin
					wb4_cyc_o <= 1'b1;
					wb4_stb_o <= 1'b1;
					wb4_we_o  <= 1'b0;
				end
				pi1_pkg::PI1_RW: begin
					wb4_cyc_o  <= 1'b1;
					wb4_stb_o  <= 1'b1;
					wb4_we_o   <= 1'b0; // read half first.
					wr_pending <= 1'b1;
				end
				default: begin
					wb4_cyc_o <= 1'b0;
					wb4_stb_o <= 1'b0;
					wb4_we_o  <= 1'b0;
				end
			endcase
		end else if (wr_pending && wb4_ack_i) begin
			// old word is in, issue the write half.
			wb4_stb_o  <= 1'b1;
			wb4_we_o   <= 1'b1;
			wr_pending <= 1'b0;
		end else if (!wb4_stall_i) begin
			wb4_stb_o <= 1'b0; // request accepted.
		end
	end

	// request payload, steady until the next operation.
	always_ff @(posedge clk_i) begin
		if (pi1_rdy_o) begin
			wb4_addr_o <= byte_addr;
			wb4_data_o <= pi1_data_i;
			wb4_sel_o  <= pi1_sel_i;
		end
		if (wr_pending && wb4_ack_i)
			rd_hold <= wb4_data_i;
	end

endmodule

//--- src/pi1_wb_top.sv
// pi1 port over wishbone memory
`timescale 1ns/100ps

module pi1_wb_top (
	input  logic                            clk_i,
	input  logic                            rst_i,

	input  pi1_pkg::pi1_op_e                pi1_op_i,
	input  logic [pi1_pkg::ADDR_W-1:0]      pi1_addr_i,
	input  logic [pi1_pkg::ARCH_W-1:0]      pi1_data_i,
	input  logic [pi1_pkg::SEL_W-1:0]       pi1_sel_i,
	output logic [pi1_pkg::ARCH_W-1:0]      pi1_data_o,
	output logic                            pi1_rdy_o,

	input  logic                            cfg_we_i,
	input  logic [wb_pkg::WAIT_W-1:0]       cfg_wait_i
);

	logic                            wb4_cyc;
	logic                            wb4_stb;
	logic                            wb4_we;
	logic [wb_pkg::WB_ADDR_W-1:0]    wb4_addr;
	logic [pi1_pkg::ARCH_W-1:0]      wb4_wdata;
	logic [pi1_pkg::SEL_W-1:0]       wb4_sel;
	logic                            wb4_stall;
	logic                            wb4_ack;
	logic [pi1_pkg::ARCH_W-1:0]      wb4_rdata;

	pi1_to_wb4 bridge_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.pi1_op_i    (pi1_op_i),
		.pi1_addr_i  (pi1_addr_i),
		.pi1_data_i  (pi1_data_i),
		.pi1_sel_i   (pi1_sel_i),
		.pi1_data_o  (pi1_data_o),
		.pi1_rdy_o   (pi1_rdy_o),
		.wb4_cyc_o   (wb4_cyc),
		.wb4_stb_o   (wb4_stb),
		.wb4_we_o    (wb4_we),
		.wb4_addr_o  (wb4_addr),
		.wb4_data_o  (wb4_wdata),
		.wb4_sel_o   (wb4_sel),
		.wb4_stall_i (wb4_stall),
		.wb4_ack_i   (wb4_ack),
		.wb4_data_i  (wb4_rdata)
	);

	// stall line shared by memory and bridge.
	wb4_wait_cfg wait_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cfg_we_i    (cfg_we_i),
		.cfg_wait_i  (cfg_wait_i),
		.wb4_cyc_i   (wb4_cyc),
		.wb4_stb_i   (wb4_stb),
		.wb4_stall_o (wb4_stall)
	);

	wb4_sram sram_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.wb4_cyc_i   (wb4_cyc),
		.wb4_stb_i   (wb4_stb),
		.wb4_we_i    (wb4_we),
		.wb4_addr_i  (wb4_addr),
		.wb4_data_i  (wb4_wdata),
		.wb4_sel_i   (wb4_sel),
		.wb4_stall_i (wb4_stall),
		.wb4_ack_o   (wb4_ack),
		.wb4_data_o  (wb4_rdata)
	);

endmodule

//--- src/wb4_sram.sv
// wishbone b4 pipelined memory
`timescale 1ns/100ps

module wb4_sram (
	input  logic                            clk_i,
	input  logic                            rst_i,

	input  logic                            wb4_cyc_i,
	input  logic                            wb4_stb_i,
	input  logic                            wb4_we_i,
	input  logic [wb_pkg::WB_ADDR_W-1:0]    wb4_addr_i,
	input  logic [pi1_pkg::ARCH_W-1:0]      wb4_data_i,
	input  logic [pi1_pkg::SEL_W-1:0]       wb4_sel_i,
	input  logic                            wb4_stall_i,
	output logic                            wb4_ack_o,
	output logic [pi1_pkg::ARCH_W-1:0]      wb4_data_o
);

	logic [pi1_pkg::ARCH_W-1:0]    mem [wb_pkg::MEM_WORDS];
	logic [wb_pkg::MEM_AW-1:0]     idx;
	logic                          accept;
	logic [pi1_pkg::ARCH_W-1:0]    rd_q;

	// word index sits right above the byte offset.
	assign idx = wb4_addr_i[wb_pkg::MEM_AW + pi1_pkg::OFF_W - 1:pi1_pkg::OFF_W];

	assign accept = wb4_cyc_i && wb4_stb_i && !wb4_stall_i;

	always_ff @(posedge clk_i) begin
		if (accept) begin
			if (wb4_we_i) begin
				for (int b = 0; b < pi1_pkg::SEL_W; b++) begin
					if (wb4_sel_i[b])
						mem[idx][b*8 +: 8] <= wb4_data_i[b*8 +: 8];
				end
			end else begin
				rd_q <= mem[idx];
			end
		end
	end

	// ack one cycle after acceptance.
	always_ff @(posedge clk_i) begin
		if (rst_i)
			wb4_ack_o <= 1'b0;
		else
			wb4_ack_o <= accept;
	end

	assign wb4_data_o = rd_q; // held until the next read.

endmodule

//--- src/wb4_wait_cfg.sv
// memory wait-state control
`timescale 1ns/100ps

module wb4_wait_cfg (
	input  logic                        clk_i,
	input  logic                        rst_i,

	input  logic                        cfg_we_i,
	input  logic [wb_pkg::WAIT_W-1:0]   cfg_wait_i,

	input  logic                        wb4_cyc_i,
	input  logic                        wb4_stb_i,
	output logic                        wb4_stall_o
);

	logic [wb_pkg::WAIT_W-1:0]   wait_q;
	logic [wb_pkg::WAIT_W-1:0]   cnt_q;
	logic                        req_q; // request seen, not yet accepted.
	logic                        new_req;

	assign new_req = wb4_cyc_i && wb4_stb_i && !req_q;

	// first stall cycle comes straight from the register.
	assign wb4_stall_o = (cnt_q != '0) || (new_req && wait_q != '0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wait_q <= '0;
			cnt_q  <= '0;
			req_q  <= 1'b0;
		end else begin
			if (cfg_we_i)
				wait_q <= cfg_wait_i;

			if (new_req && wait_q != '0)
				cnt_q <= wait_q - 1'b1;
			else if (cnt_q != '0)
				cnt_q <= cnt_q - 1'b1;

			if (wb4_stb_i && !wb4_stall_o)
				req_q <= 1'b0;
			else if (new_req)
				req_q <= 1'b1;
		end
	end

endmodule

//--- src/wb_pkg.sv
// wishbone and memory definitions

package wb_pkg;

	// byte address on the bus.
	localparam int WB_ADDR_W = 32;

	// memory depth in words.
	localparam int MEM_WORDS = 256;

	// word index width, taken from address bits above the byte offset.
	localparam int MEM_AW = 8;

	// width of the configured stall count.
	localparam int WAIT_W = 3;

endpackage

//--- tb.f
src/pi1_pkg.sv
src/wb_pkg.sv
src/pi1_to_wb4.sv
src/wb4_sram.sv
src/wb4_wait_cfg.sv
src/pi1_wb_top.sv
tests/pi1_wb_properties.sv
tests/tb_pi1_wb.sv

//--- tests/pi1_wb_cases.txt
# name op wait addr sel data expected; op is wr, rd or rw, wait decimal, the rest hex
# expected is the word returned for rd and rw, and the word held after a wr
full_wr      wr 0 00000010 f deadbeef deadbeef
full_rd      rd 0 00000010 f 00000000 deadbeef
lane_base    wr 0 00000020 f 11223344 11223344
lane_b0      wr 0 00000020 1 aabbccdd 112233dd
lane_b2      wr 0 00000020 4 55667788 116633dd
lane_b1_b3   wr 0 00000020 a 99aabbcc 9966bbdd
lane_none    wr 0 00000020 0 ffffffff 9966bbdd
lane_rd      rd 0 00000020 f 00000000 9966bbdd
swap_base    wr 0 00000030 f 01234567 01234567
swap_full    rw 0 00000030 f cafef00d 01234567
swap_rd      rd 0 00000030 f 00000000 cafef00d
swap_low     rw 0 00000020 3 00000000 9966bbdd
swap_low_rd  rd 0 00000020 f 00000000 99660000
w3_wr        wr 3 00000040 f 0badf00d 0badf00d
w3_rd        rd 3 00000040 f 00000000 0badf00d
w3_swap      rw 3 00000040 f 12345678 0badf00d
w3_swap_rd   rd 3 00000040 f 00000000 12345678
w7_wr        wr 7 000000ff f a5a55a5a a5a55a5a
w7_rd        rd 7 000000ff f 00000000 a5a55a5a
w7_swap      rw 7 000000ff c 5a5aa5a5 a5a55a5a
w7_swap_rd   rd 7 000000ff f 00000000 5a5a5a5a
w7_old_rd    rd 7 00000010 f 00000000 deadbeef
alias_rd     rd 0 3fffff10 f 00000000 deadbeef
w0_back_rd   rd 0 00000030 f 00000000 cafef00d

//--- tests/pi1_wb_properties.sv
// bridge bus and handshake assertions
`timescale 1ns/100ps

module pi1_wb_properties (
	input logic                            clk_i,
	input logic                            rst_i,
	input logic                            rdy_i,
	input logic                            cyc_i,
	input logic                            stb_i,
	input logic [wb_pkg::WB_ADDR_W-1:0]    addr_i,
	input logic                            stall_i,
	input logic                            ack_i
);

	logic accept;

	assign accept = cyc_i && stb_i && !stall_i;

	reset_idle: assert property (@(posedge clk_i) rst_i |=> !cyc_i && !stb_i)
		else $error("cyc or stb high after reset");

	stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		stb_i && stall_i |=> stb_i && $stable(addr_i))
		else $error("request dropped or address moved while stalled");

	ack_timing: assert property (@(posedge clk_i) disable iff (rst_i) accept |=> ack_i)
		else $error("no ack one cycle after acceptance");

	ack_source: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |-> $past(accept))
		else $error("ack without a request accepted the cycle before");

	stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i && !rdy_i)
		else $error("stb high outside a cycle or while ready");

endmodule

bind pi1_to_wb4 pi1_wb_properties props_i (
	.clk_i   (clk_i),
	.rst_i   (rst_i),
	.rdy_i   (pi1_rdy_o),
	.cyc_i   (wb4_cyc_o),
	.stb_i   (wb4_stb_o),
	.addr_i  (wb4_addr_o),
	.stall_i (wb4_stall_i),
	.ack_i   (wb4_ack_i)
);

//--- tests/tb_pi1_wb.sv
// pi1 to wishbone subsystem testbench
`timescale 1ns/100ps

module tb_pi1_wb;

	localparam int CLK_PERIOD  = 100;
	localparam int RST_CYCLES  = 5;
	localparam int CASE_CYCLES = 6 + 2 * 7 + 4; // slowest swap plus idle slack.

	logic                          clk_i;
	logic                          rst_i;
	pi1_pkg::pi1_op_e              pi1_op_i;
	logic [pi1_pkg::ADDR_W-1:0]    pi1_addr_i;
	logic [pi1_pkg::ARCH_W-1:0]    pi1_data_i;
	logic [pi1_pkg::SEL_W-1:0]     pi1_sel_i;
	logic [pi1_pkg::ARCH_W-1:0]    pi1_data_o;
	logic                          pi1_rdy_o;
	logic                          cfg_we_i;
	logic [wb_pkg::WAIT_W-1:0]     cfg_wait_i;

	string                         c_name [$];
	pi1_pkg::pi1_op_e              c_op [$];
	int                            c_wait [$];
	logic [pi1_pkg::ADDR_W-1:0]    c_addr [$];
	logic [pi1_pkg::SEL_W-1:0]     c_sel [$];
	logic [pi1_pkg::ARCH_W-1:0]    c_data [$];
	logic [pi1_pkg::ARCH_W-1:0]    c_exp [$];
	logic [pi1_pkg::ARCH_W-1:0]    shadow [wb_pkg::MEM_WORDS]; // expected memory contents.
	bit                            written [wb_pkg::MEM_WORDS];
	bit                            loaded;

	pi1_wb_top dut_i (.*);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_data(input string name, input logic [pi1_pkg::ARCH_W-1:0] exp,
			input logic [pi1_pkg::ARCH_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("ERR %s: expected %08h, actual %08h", name, exp, act));
	endtask

	task automatic check_op_done(input string name, input int bound, input int cycles);
		if (cycles > bound)
			abort_run($sformatf("ERR %s: expected ready within %0d cycles, actual %0d",
				name, bound, cycles));
	endtask

	task automatic load_cases();
		int fd;
		int n;
		int w;
		string line;
		string name;
		string op_s;
		logic [pi1_pkg::ADDR_W-1:0] addr;
		logic [pi1_pkg::SEL_W-1:0] sel;
		logic [pi1_pkg::ARCH_W-1:0] data;
		logic [pi1_pkg::ARCH_W-1:0] exp;
		fd = $fopen("tests/pi1_wb_cases.txt", "r");
		if (fd == 0)
			abort_run("cannot open tests/pi1_wb_cases.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %s %d %h %h %h %h", name, op_s, w, addr, sel, data, exp);
			if (n < 1)
				continue; // blank line.
			if (n != 7 || w < 0 || w > (1 << wb_pkg::WAIT_W) - 1)
				abort_run({"malformed case line: ", line});
			case (op_s)
				"wr": c_op.push_back(pi1_pkg::PI1_WR);
				"rd": c_op.push_back(pi1_pkg::PI1_RD);
				"rw": c_op.push_back(pi1_pkg::PI1_RW);
				default: abort_run({"unknown operation in case ", name});
			endcase
			c_name.push_back(name);
			c_wait.push_back(w);
			c_addr.push_back(addr);
			c_sel.push_back(sel);
			c_data.push_back(data);
			c_exp.push_back(exp);
		end
		$fclose(fd);
		if (c_name.size() == 0)
			abort_run("case file holds no cases");
	endtask

	task automatic run_case(input int k);
		int idx;
		int bound;
		int cycles;
		logic [pi1_pkg::ARCH_W-1:0] old;
		idx = int'(c_addr[k][wb_pkg::MEM_AW-1:0]); // byte address bits 9:2.
		bound = (c_op[k] == pi1_pkg::PI1_RW) ? 6 + 2 * c_wait[k] : 3 + c_wait[k];
		if (c_op[k] != pi1_pkg::PI1_WR && !written[idx])
			abort_run({"case reads a word that was never written: ", c_name[k]});
		old = shadow[idx];
		@(posedge clk_i);
		cfg_we_i   <= 1'b1;
		cfg_wait_i <= wb_pkg::WAIT_W'(c_wait[k]);
		@(posedge clk_i);
		cfg_we_i <= 1'b0;
		repeat (int'($urandom % 3)) @(posedge clk_i);
		pi1_op_i   <= c_op[k];
		pi1_addr_i <= c_addr[k];
		pi1_data_i <= c_data[k];
		pi1_sel_i  <= c_sel[k];
		@(posedge clk_i);
		pi1_op_i <= pi1_pkg::PI1_NOP; // operation taken at this edge.
		cycles = 0;
		do begin
			@(negedge clk_i);
			cycles++;
		end while (!pi1_rdy_o && cycles <= bound);
		check_op_done(c_name[k], bound, cycles);
		if (c_op[k] != pi1_pkg::PI1_RD) begin
			for (int b = 0; b < pi1_pkg::SEL_W; b++)
				if (c_sel[k][b])
					shadow[idx][b*8 +: 8] = c_data[k][b*8 +: 8];
			written[idx] = 1'b1;
		end
		if (c_op[k] == pi1_pkg::PI1_WR) begin
			check_data({c_name[k], " model"}, c_exp[k], shadow[idx]);
		end else begin
			check_data({c_name[k], " model"}, c_exp[k], old);
			check_data(c_name[k], old, pi1_data_o);
		end
	endtask

	initial begin
		void'($urandom(93834));
		rst_i      = 1'b1;
		pi1_op_i   = pi1_pkg::PI1_NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i  = '0;
		cfg_we_i   = 1'b0;
		cfg_wait_i = '0;
		load_cases();
		loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		if (pi1_rdy_o !== 1'b1)
			abort_run("ready is low after reset");
		for (int k = 0; k < c_name.size(); k++)
			run_case(k);
		$display("TEST RESULT: PASS");
		$finish;
	end

	// watchdog.
	initial begin
		wait (loaded);
		#((c_name.size() * CASE_CYCLES + RST_CYCLES) * CLK_PERIOD);
		abort_run("watchdog expired before all cases finished");
	end

endmodule
